/* rtl/mem_shim_pkg.sv */
// ====================
// Memory shim package
// Widths, payload types, sorter state and read credit
// constants shared by the shim stack
// ====================

package mem_shim_pkg;

    // Line address and line data carried on both channels
    typedef logic [15:0] addr_t;
    typedef logic [31:0] data_t;

    // Accelerator request tag, returned unchanged with the response
    typedef logic [7:0] mdata_t;

    // Sorter slot index, sent to the host in place of mdata on reads
    typedef logic [3:0] tag_t;

    // In-flight counter, one bit wider than tag_t so it can hold a full count
    typedef logic [4:0] cnt_t;

    // Number of sorter slots and the hard cap on reads in flight
    localparam int MAX_ACTIVE_READS = 16;

    // Requests the accelerator may still issue after it sees almost-full
    localparam int ALMOST_FULL_SLACK = 4;

    // Output state of the read response sorter
    typedef enum logic
    {
        idle,
        emit
    } sort_state_t;

endpackage

/* rtl/read_rsp_sorter.sv */
// ====================
// Read response sorter
// Tags each read with a slot index, keeps the accelerator mdata
// per slot and returns read data in request order
// ====================

`timescale 1ns/1ns

module read_rsp_sorter
(
    input  logic                 clk,
    input  logic                 reset,

    // Reads from the accelerator
    input  logic                 c0_req_valid,
    input  mem_shim_pkg::addr_t  c0_req_addr,
    input  mem_shim_pkg::mdata_t c0_req_mdata,

    // Read responses from the host, possibly out of order
    input  logic                 fiu_c0_rsp_valid,
    input  mem_shim_pkg::data_t  fiu_c0_rsp_data,
    input  mem_shim_pkg::tag_t   fiu_c0_rsp_tag,

    // Tagged reads toward the credit limiter
    output logic                 sort_c0_req_valid,
    output mem_shim_pkg::addr_t  sort_c0_req_addr,
    output mem_shim_pkg::tag_t   sort_c0_req_tag,

    // Ordered read responses to the accelerator
    output logic                 c0_rsp_valid,
    output mem_shim_pkg::data_t  c0_rsp_data,
    output mem_shim_pkg::mdata_t c0_rsp_mdata
);

    // Slot storage, indexed by tag
    mem_shim_pkg::mdata_t slot_mdata [mem_shim_pkg::MAX_ACTIVE_READS];
    mem_shim_pkg::data_t  slot_data  [mem_shim_pkg::MAX_ACTIVE_READS];

    // One bit per slot, set when the host data has landed
    logic [mem_shim_pkg::MAX_ACTIVE_READS-1:0] slot_filled;

    // Allocation and retirement pointers, both wrap at the slot count
    mem_shim_pkg::tag_t alloc_ptr;
    mem_shim_pkg::tag_t head_ptr;

    mem_shim_pkg::sort_state_t state;
    mem_shim_pkg::sort_state_t state_next;

    logic head_ready;

    // ====================
    // Request tagging
    // ====================

    // Reads pass straight on with the next free slot as their tag.
    // The limiter adds the register stage toward the host
    assign sort_c0_req_valid = c0_req_valid;
    assign sort_c0_req_addr  = c0_req_addr;
    assign sort_c0_req_tag   = alloc_ptr;

    // ====================
    // Output FSM
    // ====================

    // The oldest read may leave once its data is in the slot
    assign head_ready = slot_filled[head_ptr];

    // The emit state means the output registers hold a response this cycle.
    // Back-to-back filled heads keep the FSM in emit, one response per cycle
    always_comb
    begin
        state_next = head_ready ? mem_shim_pkg::emit : mem_shim_pkg::idle;
    end

    assign c0_rsp_valid = (state == mem_shim_pkg::emit);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= mem_shim_pkg::idle;
            alloc_ptr   <= '0;
            head_ptr    <= '0;
            slot_filled <= '0;
        end
        else
        begin
            state <= state_next;

            if (c0_req_valid)
            begin
                alloc_ptr <= alloc_ptr + mem_shim_pkg::tag_t'(1);
            end

            // Retire the head slot as it moves into the output registers
            if (head_ready)
            begin
                slot_filled[head_ptr] <= 1'b0;
                head_ptr <= head_ptr + mem_shim_pkg::tag_t'(1);
            end

            // A landing response never targets the head being retired,
            // so this set does not race the clear above
            if (fiu_c0_rsp_valid)
            begin
                slot_filled[fiu_c0_rsp_tag] <= 1'b1;
            end
        end
    end

    // Slot memories and the output payload
    always_ff @(posedge clk)
    begin
        if (c0_req_valid)
        begin
            slot_mdata[alloc_ptr] <= c0_req_mdata;
        end

        if (fiu_c0_rsp_valid)
        begin
            slot_data[fiu_c0_rsp_tag] <= fiu_c0_rsp_data;
        end

        if (head_ready)
        begin
            c0_rsp_data  <= slot_data[head_ptr];
            c0_rsp_mdata <= slot_mdata[head_ptr];
        end
    end

    // The host answers each tag once, so a response must find its slot pending
    a_no_double_fill: assert property (@(posedge clk) disable iff (reset)
        fiu_c0_rsp_valid |-> !slot_filled[fiu_c0_rsp_tag]);

endmodule

/* rtl/req_credit_limiter.sv */
// ====================
// Request credit limiter
// Registers requests toward the host, counts reads in flight
// and raises almost-full toward the accelerator with slack left
// ====================

`timescale 1ns/1ns

module req_credit_limiter
(
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 sort_c0_req_valid,
    input  mem_shim_pkg::addr_t  sort_c0_req_addr,
    input  mem_shim_pkg::tag_t   sort_c0_req_tag,

    input  logic                 c1_req_valid,
    input  mem_shim_pkg::addr_t  c1_req_addr,
    input  mem_shim_pkg::data_t  c1_req_data,
    input  mem_shim_pkg::mdata_t c1_req_mdata,

    input  logic                 fiu_c0_rsp_valid,
    input  logic                 fiu_c1_rsp_valid,
    input  mem_shim_pkg::mdata_t fiu_c1_rsp_mdata,
    input  logic                 fiu_almost_full,

    output logic                 fiu_c0_req_valid,
    output mem_shim_pkg::addr_t  fiu_c0_req_addr,
    output mem_shim_pkg::tag_t   fiu_c0_req_tag,

    output logic                 fiu_c1_req_valid,
    output mem_shim_pkg::addr_t  fiu_c1_req_addr,
    output mem_shim_pkg::data_t  fiu_c1_req_data,
    output mem_shim_pkg::mdata_t fiu_c1_req_mdata,

    output logic                 c1_rsp_valid,
    output mem_shim_pkg::mdata_t c1_rsp_mdata,
    output logic                 almost_full
);

    // Reads counted from entry into the host edge register until the host answers
    mem_shim_pkg::cnt_t reads_in_flight;

    // The accelerator sees almost-full the cycle after the count reaches the
    // threshold, and its slack then lands exactly on the slot count
    assign almost_full = fiu_almost_full ||
        (reads_in_flight >= mem_shim_pkg::cnt_t'(mem_shim_pkg::MAX_ACTIVE_READS -
                                                  mem_shim_pkg::ALMOST_FULL_SLACK));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fiu_c0_req_valid <= 1'b0;
            fiu_c1_req_valid <= 1'b0;
            c1_rsp_valid     <= 1'b0;
            reads_in_flight  <= '0;
        end
        else
        begin
            fiu_c0_req_valid <= sort_c0_req_valid;
            fiu_c1_req_valid <= c1_req_valid;
            c1_rsp_valid     <= fiu_c1_rsp_valid;

            // An issue and a response in the same cycle cancel out
            if (sort_c0_req_valid != fiu_c0_rsp_valid)
            begin
                if (sort_c0_req_valid)
                    reads_in_flight <= reads_in_flight + mem_shim_pkg::cnt_t'(1);
                else
                    reads_in_flight <= reads_in_flight - mem_shim_pkg::cnt_t'(1);
            end
        end
    end

    // Payload follows its valid through the same stage
    always_ff @(posedge clk)
    begin
        fiu_c0_req_addr  <= sort_c0_req_addr;
        fiu_c0_req_tag   <= sort_c0_req_tag;
        fiu_c1_req_addr  <= c1_req_addr;
        fiu_c1_req_data  <= c1_req_data;
        fiu_c1_req_mdata <= c1_req_mdata;
        c1_rsp_mdata     <= fiu_c1_rsp_mdata;
    end

    // Holds only while the accelerator honours the almost-full slack
    a_read_cap: assert property (@(posedge clk) disable iff (reset)
        reads_in_flight <= mem_shim_pkg::cnt_t'(mem_shim_pkg::MAX_ACTIVE_READS));

endmodule

/* rtl/activity_tracker.sv */
// ====================
// Activity tracker
// Counts outstanding reads and writes at the accelerator edge
// and reports whether each channel still has work in flight
// ====================

`timescale 1ns/1ns

module activity_tracker
(
    input  logic clk,
    input  logic reset,

    input  logic c0_req_valid,
    input  logic c0_rsp_valid,
    input  logic c1_req_valid,
    input  logic c1_rsp_valid,

    output logic c0_not_empty,
    output logic c1_not_empty
);

    // Index 0 is the read channel and index 1 the write channel
    logic [1:0]         active_incr;
    logic [1:0]         active_decr;
    logic [1:0]         not_empty;
    mem_shim_pkg::cnt_t num_active [2];

    assign active_incr  = {c1_req_valid, c0_req_valid};
    assign active_decr  = {c1_rsp_valid, c0_rsp_valid};
    assign c0_not_empty = not_empty[0];
    assign c1_not_empty = not_empty[1];

    for (genvar ch = 0; ch < 2; ch++)
    begin : g_chan
        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                not_empty[ch]  <= 1'b0;
                num_active[ch] <= '0;
            end
            else
            begin
                // A new request marks the channel busy before the count catches up
                not_empty[ch] <= active_incr[ch] || (|num_active[ch]);

                if (active_incr[ch] != active_decr[ch])
                begin
                    if (active_incr[ch])
                        num_active[ch] <= num_active[ch] + mem_shim_pkg::cnt_t'(1);
                    else
                        num_active[ch] <= num_active[ch] - mem_shim_pkg::cnt_t'(1);
                end
            end
        end

        // Every response seen here must match a request seen earlier
        a_no_underflow: assert property (@(posedge clk) disable iff (reset)
            active_decr[ch] |-> (num_active[ch] != '0));
    end

endmodule

/* rtl/mem_shim_top.sv */
// ====================
// Memory shim top level
// Connects the read sorter, credit limiter and activity tracker
// between the accelerator port and the host port
// ====================

`timescale 1ns/1ns

module mem_shim_top
(
    input  logic                 clk,
    input  logic                 reset,

    // Accelerator side
    input  logic                 c0_req_valid,
    input  mem_shim_pkg::addr_t  c0_req_addr,
    input  mem_shim_pkg::mdata_t c0_req_mdata,
    input  logic                 c1_req_valid,
    input  mem_shim_pkg::addr_t  c1_req_addr,
    input  mem_shim_pkg::data_t  c1_req_data,
    input  mem_shim_pkg::mdata_t c1_req_mdata,
    output logic                 c0_rsp_valid,
    output mem_shim_pkg::data_t  c0_rsp_data,
    output mem_shim_pkg::mdata_t c0_rsp_mdata,
    output logic                 c1_rsp_valid,
    output mem_shim_pkg::mdata_t c1_rsp_mdata,
    output logic                 almost_full,

    // Host side
    output logic                 fiu_c0_req_valid,
    output mem_shim_pkg::addr_t  fiu_c0_req_addr,
    output mem_shim_pkg::tag_t   fiu_c0_req_tag,
    output logic                 fiu_c1_req_valid,
    output mem_shim_pkg::addr_t  fiu_c1_req_addr,
    output mem_shim_pkg::data_t  fiu_c1_req_data,
    output mem_shim_pkg::mdata_t fiu_c1_req_mdata,
    input  logic                 fiu_c0_rsp_valid,
    input  mem_shim_pkg::data_t  fiu_c0_rsp_data,
    input  mem_shim_pkg::tag_t   fiu_c0_rsp_tag,
    input  logic                 fiu_c1_rsp_valid,
    input  mem_shim_pkg::mdata_t fiu_c1_rsp_mdata,
    input  logic                 fiu_almost_full,

    // Outstanding work per channel
    output logic                 c0_not_empty,
    output logic                 c1_not_empty
);

    // Tagged reads from the sorter into the limiter
    logic                sort_c0_req_valid;
    mem_shim_pkg::addr_t sort_c0_req_addr;
    mem_shim_pkg::tag_t  sort_c0_req_tag;

    // Reads only, writes go straight to the limiter
    read_rsp_sorter read_rsp_sorter_inst
    (
        .clk               (clk),
        .reset             (reset),
        .c0_req_valid      (c0_req_valid),
        .c0_req_addr       (c0_req_addr),
        .c0_req_mdata      (c0_req_mdata),
        .fiu_c0_rsp_valid  (fiu_c0_rsp_valid),
        .fiu_c0_rsp_data   (fiu_c0_rsp_data),
        .fiu_c0_rsp_tag    (fiu_c0_rsp_tag),
        .sort_c0_req_valid (sort_c0_req_valid),
        .sort_c0_req_addr  (sort_c0_req_addr),
        .sort_c0_req_tag   (sort_c0_req_tag),
        .c0_rsp_valid      (c0_rsp_valid),
        .c0_rsp_data       (c0_rsp_data),
        .c0_rsp_mdata      (c0_rsp_mdata)
    );

    // Sits at the host edge so its read count sees the host traffic directly
    req_credit_limiter req_credit_limiter_inst
    (
        .clk               (clk),
        .reset             (reset),
        .sort_c0_req_valid (sort_c0_req_valid),
        .sort_c0_req_addr  (sort_c0_req_addr),
        .sort_c0_req_tag   (sort_c0_req_tag),
        .c1_req_valid      (c1_req_valid),
        .c1_req_addr       (c1_req_addr),
        .c1_req_data       (c1_req_data),
        .c1_req_mdata      (c1_req_mdata),
        .fiu_c0_rsp_valid  (fiu_c0_rsp_valid),
        .fiu_c1_rsp_valid  (fiu_c1_rsp_valid),
        .fiu_c1_rsp_mdata  (fiu_c1_rsp_mdata),
        .fiu_almost_full   (fiu_almost_full),
        .fiu_c0_req_valid  (fiu_c0_req_valid),
        .fiu_c0_req_addr   (fiu_c0_req_addr),
        .fiu_c0_req_tag    (fiu_c0_req_tag),
        .fiu_c1_req_valid  (fiu_c1_req_valid),
        .fiu_c1_req_addr   (fiu_c1_req_addr),
        .fiu_c1_req_data   (fiu_c1_req_data),
        .fiu_c1_req_mdata  (fiu_c1_req_mdata),
        .c1_rsp_valid      (c1_rsp_valid),
        .c1_rsp_mdata      (c1_rsp_mdata),
        .almost_full       (almost_full)
    );

    // Watches the accelerator edge only
    activity_tracker activity_tracker_inst
    (
        .clk          (clk),
        .reset        (reset),
        .c0_req_valid (c0_req_valid),
        .c0_rsp_valid (c0_rsp_valid),
        .c1_req_valid (c1_req_valid),
        .c1_rsp_valid (c1_rsp_valid),
        .c0_not_empty (c0_not_empty),
        .c1_not_empty (c1_not_empty)
    );

endmodule

/* dv/host_mem_model.sv */
// ====================
// Host memory model
// Answers reads out of order and writes in order,
// with stall and almost-full controls from the testbench
// ====================

`timescale 1ns/1ns

module host_mem_model
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 force_af,
    input  logic                 fiu_c0_req_valid,
    input  mem_shim_pkg::addr_t  fiu_c0_req_addr,
    input  mem_shim_pkg::tag_t   fiu_c0_req_tag,
    input  logic                 fiu_c1_req_valid,
    input  mem_shim_pkg::addr_t  fiu_c1_req_addr,
    input  mem_shim_pkg::data_t  fiu_c1_req_data,
    input  mem_shim_pkg::mdata_t fiu_c1_req_mdata,
    output logic                 fiu_c0_rsp_valid,
    output mem_shim_pkg::data_t  fiu_c0_rsp_data,
    output mem_shim_pkg::tag_t   fiu_c0_rsp_tag,
    output logic                 fiu_c1_rsp_valid,
    output mem_shim_pkg::mdata_t fiu_c1_rsp_mdata,
    output logic                 fiu_almost_full
);

    // Sparse host memory; unwritten lines read back a pattern of their address
    mem_shim_pkg::data_t  mem [mem_shim_pkg::addr_t];
    mem_shim_pkg::tag_t   rd_tag_q [$];
    mem_shim_pkg::data_t  rd_data_q [$];
    mem_shim_pkg::mdata_t wr_mdata_q [$];
    logic                 hold;
    integer               seed;
    int                   pick;

    // Almost-full follows the testbench control with no delay
    assign fiu_almost_full = force_af;

    initial
    begin
        seed             = 32'h557d_b602;
        hold             = 1'b1;
        fiu_c0_rsp_valid = 1'b0;
        fiu_c0_rsp_data  = '0;
        fiu_c0_rsp_tag   = '0;
        fiu_c1_rsp_valid = 1'b0;
        fiu_c1_rsp_mdata = '0;
    end

    // Requests are taken on the rising edge, as the DUT launches them
    always @(posedge clk)
    begin
        hold = reset || stall;
        if (reset)
        begin
            rd_tag_q.delete();
            rd_data_q.delete();
            wr_mdata_q.delete();
        end
        else
        begin
            if (fiu_c1_req_valid)
            begin
                mem[fiu_c1_req_addr] = fiu_c1_req_data;
                wr_mdata_q.push_back(fiu_c1_req_mdata);
            end
            if (fiu_c0_req_valid)
            begin
                rd_tag_q.push_back(fiu_c0_req_tag);
                if (mem.exists(fiu_c0_req_addr))
                    rd_data_q.push_back(mem[fiu_c0_req_addr]);
                else
                    rd_data_q.push_back({16'h0000, fiu_c0_req_addr ^ 16'h5a5a});
            end
        end
    end

    // Responses launch on the falling edge, one per channel per cycle
    always @(negedge clk)
    begin
        fiu_c0_rsp_valid = 1'b0;
        fiu_c1_rsp_valid = 1'b0;
        if (!hold)
        begin
            // Reads are held at random, so any held one may go next
            if (rd_tag_q.size() != 0 && ($random(seed) & 1) != 0)
            begin
                pick             = $unsigned($random(seed)) % rd_tag_q.size();
                fiu_c0_rsp_valid = 1'b1;
                fiu_c0_rsp_tag   = rd_tag_q[pick];
                fiu_c0_rsp_data  = rd_data_q[pick];
                rd_tag_q.delete(pick);
                rd_data_q.delete(pick);
            end
            if (wr_mdata_q.size() != 0 && ($random(seed) & 1) != 0)
            begin
                fiu_c1_rsp_valid = 1'b1;
                fiu_c1_rsp_mdata = wr_mdata_q.pop_front();
            end
        end
    end

endmodule

/* dv/mem_shim_checker.sv */
// ====================
// Memory shim checker
// Watches the accelerator and host ports of the DUT and
// compares responses and flags against the expected model
// ====================

`timescale 1ns/1ns

module mem_shim_checker
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 c0_req_valid,
    input  mem_shim_pkg::addr_t  c0_req_addr,
    input  mem_shim_pkg::mdata_t c0_req_mdata,
    input  logic                 c1_req_valid,
    input  mem_shim_pkg::addr_t  c1_req_addr,
    input  mem_shim_pkg::data_t  c1_req_data,
    input  mem_shim_pkg::mdata_t c1_req_mdata,
    input  logic                 c0_rsp_valid,
    input  mem_shim_pkg::data_t  c0_rsp_data,
    input  mem_shim_pkg::mdata_t c0_rsp_mdata,
    input  logic                 c1_rsp_valid,
    input  mem_shim_pkg::mdata_t c1_rsp_mdata,
    input  logic                 almost_full,
    input  logic                 fiu_almost_full,
    input  logic                 fiu_c0_req_valid,
    input  logic                 fiu_c1_req_valid,
    input  logic                 c0_not_empty,
    input  logic                 c1_not_empty,
    output int                   check_errors,
    output int                   rd_outstanding,
    output int                   wr_outstanding
);

    // Last data written per address, as seen at the accelerator edge
    mem_shim_pkg::data_t  written [mem_shim_pkg::addr_t];
    mem_shim_pkg::mdata_t rd_mdata_q [$];
    mem_shim_pkg::data_t  rd_data_q [$];
    mem_shim_pkg::mdata_t wr_mdata_q [$];
    mem_shim_pkg::mdata_t exp_mdata;
    logic                 in_reset;

    // Accelerator request valids of the previous cycle
    logic                 c0_req_last;
    logic                 c1_req_last;

    // Expected line contents: the last write, or else the address pattern
    function automatic mem_shim_pkg::data_t expected_read(input mem_shim_pkg::addr_t addr);
        if (written.exists(addr))
            return written[addr];
        return {16'h0000, addr ^ 16'h5a5a};
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
            check_errors++;
        end
    endtask

    initial
    begin
        check_errors   = 0;
        rd_outstanding = 0;
        wr_outstanding = 0;
        in_reset       = 1'b0;
        c0_req_last    = 1'b0;
        c1_req_last    = 1'b0;
    end

    always @(posedge clk)
    begin
        if (reset)
        begin
            in_reset    = 1'b1;
            c0_req_last = 1'b0;
            c1_req_last = 1'b0;
        end
        else
        begin
            // ====================
            // First cycle after reset
            // ====================
            if (in_reset)
            begin
                compare("c0_rsp_valid", c0_rsp_valid, 0);
                compare("c1_rsp_valid", c1_rsp_valid, 0);
                compare("fiu_c0_req_valid", fiu_c0_req_valid, 0);
                compare("fiu_c1_req_valid", fiu_c1_req_valid, 0);
                compare("c0_not_empty", c0_not_empty, 0);
                compare("c1_not_empty", c1_not_empty, 0);
                compare("almost_full", almost_full, fiu_almost_full);
                in_reset = 1'b0;
            end

            // Host almost-full must reach the accelerator in the same cycle
            if (fiu_almost_full)
                compare("almost_full", almost_full, 1);

            // Requests reach the host exactly one cycle after the accelerator
            compare("fiu_c0_req_valid", fiu_c0_req_valid, c0_req_last);
            compare("fiu_c1_req_valid", fiu_c1_req_valid, c1_req_last);
            c0_req_last = c0_req_valid;
            c1_req_last = c1_req_valid;

            // Flags are judged on the counts before this cycle's traffic
            if (rd_outstanding != 0)
                compare("c0_not_empty", c0_not_empty, 1);
            if (wr_outstanding != 0)
                compare("c1_not_empty", c1_not_empty, 1);

            // ====================
            // Requests and responses
            // ====================
            if (c1_req_valid)
            begin
                written[c1_req_addr] = c1_req_data;
                wr_mdata_q.push_back(c1_req_mdata);
                wr_outstanding++;
            end
            if (c0_req_valid)
            begin
                rd_mdata_q.push_back(c0_req_mdata);
                rd_data_q.push_back(expected_read(c0_req_addr));
                rd_outstanding++;
            end
            if (c0_rsp_valid)
            begin
                if (rd_mdata_q.size() == 0)
                begin
                    $display("Error at t=%0t: read response with no read outstanding", $time);
                    check_errors++;
                end
                else
                begin
                    exp_mdata = rd_mdata_q.pop_front();
                    compare("c0_rsp_mdata", c0_rsp_mdata, exp_mdata);
                    compare("c0_rsp_data", c0_rsp_data, rd_data_q.pop_front());
                    rd_outstanding--;
                end
            end
            if (c1_rsp_valid)
            begin
                if (wr_mdata_q.size() == 0)
                begin
                    $display("Error at t=%0t: write response with no write outstanding", $time);
                    check_errors++;
                end
                else
                begin
                    exp_mdata = wr_mdata_q.pop_front();
                    compare("c1_rsp_mdata", c1_rsp_mdata, exp_mdata);
                    wr_outstanding--;
                end
            end
        end
    end

endmodule

/* dv/tb_mem_shim.sv */
// ====================
// Memory shim testbench
// Clock, reset, write and read traffic, host stall and
// almost-full phases, and the closing summary
// ====================

`timescale 1ns/1ns

module tb_mem_shim;

    localparam int TIMEOUT   = 2000;
    localparam int NUM_READS = 64;

    logic                 clk;
    logic                 reset;
    logic                 stall;
    logic                 force_af;
    logic                 c0_req_valid;
    mem_shim_pkg::addr_t  c0_req_addr;
    mem_shim_pkg::mdata_t c0_req_mdata;
    logic                 c1_req_valid;
    mem_shim_pkg::addr_t  c1_req_addr;
    mem_shim_pkg::data_t  c1_req_data;
    mem_shim_pkg::mdata_t c1_req_mdata;
    logic                 c0_rsp_valid;
    mem_shim_pkg::data_t  c0_rsp_data;
    mem_shim_pkg::mdata_t c0_rsp_mdata;
    logic                 c1_rsp_valid;
    mem_shim_pkg::mdata_t c1_rsp_mdata;
    logic                 almost_full;
    logic                 fiu_c0_req_valid;
    mem_shim_pkg::addr_t  fiu_c0_req_addr;
    mem_shim_pkg::tag_t   fiu_c0_req_tag;
    logic                 fiu_c1_req_valid;
    mem_shim_pkg::addr_t  fiu_c1_req_addr;
    mem_shim_pkg::data_t  fiu_c1_req_data;
    mem_shim_pkg::mdata_t fiu_c1_req_mdata;
    logic                 fiu_c0_rsp_valid;
    mem_shim_pkg::data_t  fiu_c0_rsp_data;
    mem_shim_pkg::tag_t   fiu_c0_rsp_tag;
    logic                 fiu_c1_rsp_valid;
    mem_shim_pkg::mdata_t fiu_c1_rsp_mdata;
    logic                 fiu_almost_full;
    logic                 c0_not_empty;
    logic                 c1_not_empty;
    int                   check_errors;
    int                   rd_outstanding;
    int                   wr_outstanding;
    int                   tb_errors;
    int                   issued;
    int                   cycles;
    integer               seed;

    mem_shim_top mem_shim_top_inst (.*);
    host_mem_model host_mem_model_inst (.*);
    mem_shim_checker mem_shim_checker_inst (.*);

    always #4 clk = ~clk;

    // Each issue task drives at a falling edge and returns one cycle later
    task automatic issue_write(input mem_shim_pkg::addr_t a, input mem_shim_pkg::data_t d,
                               input mem_shim_pkg::mdata_t m);
        c1_req_valid = 1'b1;
        c1_req_addr  = a;
        c1_req_data  = d;
        c1_req_mdata = m;
        @(negedge clk);
        c1_req_valid = 1'b0;
    endtask

    task automatic issue_read(input mem_shim_pkg::addr_t a, input mem_shim_pkg::mdata_t m);
        c0_req_valid = 1'b1;
        c0_req_addr  = a;
        c0_req_mdata = m;
        @(negedge clk);
        c0_req_valid = 1'b0;
    endtask

    // Waits for every response, then for both not-empty flags to drop
    task automatic wait_drain(input string phase);
        int n;
        n = 0;
        while ((rd_outstanding != 0 || wr_outstanding != 0) && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (rd_outstanding != 0 || wr_outstanding != 0)
        begin
            $display("Timeout: responses still missing after the %s phase", phase);
            tb_errors++;
        end
        n = 0;
        while ((c0_not_empty || c1_not_empty) && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (c0_not_empty || c1_not_empty)
        begin
            $display("Timeout: not-empty flags stayed high after the %s phase", phase);
            tb_errors++;
        end
    endtask

    // Guards against a hang outside the bounded waits
    initial
    begin
        #1000000;
        $display("Watchdog expired before the test sequence finished");
        $display("errors: checker %0d, testbench %0d", check_errors, tb_errors + 1);
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        seed         = 32'h557d_b602;
        tb_errors    = 0;
        clk          = 1'b0;
        reset        = 1'b1;
        stall        = 1'b0;
        force_af     = 1'b0;
        c0_req_valid = 1'b0;
        c0_req_addr  = '0;
        c0_req_mdata = '0;
        c1_req_valid = 1'b0;
        c1_req_addr  = '0;
        c1_req_data  = '0;
        c1_req_mdata = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // ====================
        // Writes, then reads
        // ====================
        // Addresses stay in a small window so reads hit both written
        // and never-written lines
        for (int i = 0; i < 24; i++)
            issue_write($random(seed) & 16'h003f, $random(seed), i[7:0]);
        wait_drain("write");

        issued = 0;
        cycles = 0;
        while (issued < NUM_READS && cycles < TIMEOUT)
        begin
            if (!almost_full && rd_outstanding < mem_shim_pkg::MAX_ACTIVE_READS &&
                ($random(seed) & 1) != 0)
            begin
                issue_read($random(seed) & 16'h003f, 8'h40 + issued[7:0]);
                issued++;
            end
            else
                @(negedge clk);
            cycles++;
        end
        if (issued < NUM_READS)
        begin
            $display("Timeout: only %0d of %0d reads could be issued", issued, NUM_READS);
            tb_errors++;
        end
        wait_drain("read");

        // ====================
        // Stalled host fills the credit window
        // ====================
        stall = 1'b1;
        @(negedge clk);
        issued = 0;
        while (!almost_full && issued < mem_shim_pkg::MAX_ACTIVE_READS)
        begin
            issue_read($random(seed) & 16'h003f, 8'hc0 + issued[7:0]);
            issued++;
        end
        if (issued >= mem_shim_pkg::MAX_ACTIVE_READS)
        begin
            $display("almost_full did not rise before %0d reads were outstanding", issued);
            tb_errors++;
        end
        else
        begin
            // The slack reads fill the remaining slots exactly
            for (int k = 0; k < mem_shim_pkg::ALMOST_FULL_SLACK; k++)
                issue_read($random(seed) & 16'h003f, 8'he0 + k[7:0]);
        end
        if (!almost_full)
        begin
            $display("almost_full dropped while the host was stalled");
            tb_errors++;
        end
        stall = 1'b0;
        wait_drain("stall");

        // Host almost-full with no traffic, checked each cycle by the checker
        force_af = 1'b1;
        repeat (3) @(negedge clk);
        force_af = 1'b0;
        repeat (2) @(negedge clk);

        $display("errors: checker %0d, testbench %0d", check_errors, tb_errors);
        if (check_errors == 0 && tb_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

/* project.f */
rtl/mem_shim_pkg.sv
rtl/read_rsp_sorter.sv
rtl/req_credit_limiter.sv
rtl/activity_tracker.sv
rtl/mem_shim_top.sv
dv/host_mem_model.sv
dv/mem_shim_checker.sv
dv/tb_mem_shim.sv
